//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f issue_stage.f --top-module tb_issue_stage -o Vtb
	./obj_dir/Vtb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- issue_stage.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/priority_arbiter.sv
rtl/busy_table.sv
rtl/phys_regfile.sv
rtl/issue_queue.sv
rtl/issue_stage.sv
sim/tb_issue_stage.sv

//--- rtl/busy_table.sv
`timescale 1ns/100ps
`include "issue_consts.svh"

module busy_table (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   flush,
    input  logic                   alloc_valid,
    input  logic [`PREG_W-1:0]     alloc_tag,
    input  logic [`PREG_W-1:0]     rd_tag_a,
    input  logic [`PREG_W-1:0]     rd_tag_b,
    input  issue_pkg::broadcast_t  broadcast,
    output logic                   ready_a,
    output logic                   ready_b
);

    // one bit per physical register, set while a result is outstanding
    logic [`PREG_COUNT-1:0] pending;

    logic bcast_hit_a;
    logic bcast_hit_b;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pending <= '0;
        end else if (flush) begin
            // every in-flight result is cancelled
            pending <= '0;
        end else begin
            if (broadcast.valid) begin
                pending[broadcast.tag] <= 1'b0;
            end
            // a fresh allocation beats a clear of the same tag
            if (alloc_valid) begin
                pending[alloc_tag] <= 1'b1;
            end
        end
    end

    assign bcast_hit_a = broadcast.valid && (broadcast.tag == rd_tag_a);
    assign bcast_hit_b = broadcast.valid && (broadcast.tag == rd_tag_b);

    // zero register is always ready
    assign ready_a = (rd_tag_a == `PREG_ZERO) || !pending[rd_tag_a] || bcast_hit_a;
    assign ready_b = (rd_tag_b == `PREG_ZERO) || !pending[rd_tag_b] || bcast_hit_b;

    // rename never hands out the zero register as a destination
    assert property (@(posedge CLK) disable iff (!RESET)
        alloc_valid |-> (alloc_tag != `PREG_ZERO))
        else $error("busy_table: tag 0 allocated");

endmodule

//--- rtl/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// issue queue geometry
`define IQ_DEPTH 16
`define IQ_IDX_W 4

// physical register file geometry
`define PREG_COUNT 64
`define PREG_W 6

// datapath width
`define XLEN 32

// tag 0 is the hardwired zero register
`define PREG_ZERO 6'd0

`endif

//--- rtl/issue_pkg.sv
`include "issue_consts.svh"

package issue_pkg;

    // one renamed instruction as it leaves rename
    typedef struct packed {
        logic [`PREG_W-1:0] src_a;
        logic [`PREG_W-1:0] src_b;
        logic [`PREG_W-1:0] dst;
        logic               reg_wr;
        logic [`XLEN-1:0]   instr;
        logic [`XLEN-1:0]   pc;
        logic [5:0]         alu_con;
        logic [4:0]         shamt;
        logic               mem_wr;
        logic               mem_rd;
        logic               branch;
        logic               jump;
        logic               jump_reg;
        logic               alu_src;
        logic [`XLEN-1:0]   imm;
    } dispatch_t;

    // slot contents, valid bit lives in the queue
    typedef struct packed {
        dispatch_t op;
        logic      rdy_a;
        logic      rdy_b;
    } iq_entry_t;

    // what execution receives
    typedef struct packed {
        logic [`PREG_W-1:0] dst;
        logic               reg_wr;
        logic [`XLEN-1:0]   instr;
        logic [`XLEN-1:0]   pc;
        logic [5:0]         alu_con;
        logic [4:0]         shamt;
        logic               mem_wr;
        logic               mem_rd;
        logic               branch;
        logic               jump;
        logic               jump_reg;
        logic [`XLEN-1:0]   operand_a;
        logic [`XLEN-1:0]   operand_b;
        logic [`XLEN-1:0]   mem_write_data;
    } exec_op_t;

    // one execution result per cycle at most
    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] tag;
        logic [`XLEN-1:0]   value;
    } broadcast_t;

endpackage

//--- rtl/issue_queue.sv
`timescale 1ns/100ps
`include "issue_consts.svh"

module issue_queue (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   flush,
    input  logic                   dispatch_valid,
    input  issue_pkg::dispatch_t   dispatch,
    input  logic                   src_ready_a,
    input  logic                   src_ready_b,
    input  issue_pkg::broadcast_t  broadcast,
    input  logic                   exec_stall,
    input  logic [`XLEN-1:0]       rd_data_a,
    input  logic [`XLEN-1:0]       rd_data_b,
    output logic [`PREG_W-1:0]     rd_tag_a,
    output logic [`PREG_W-1:0]     rd_tag_b,
    output logic                   iq_full,
    output logic                   issue_valid,
    output issue_pkg::exec_op_t    issue_op
);

    // slot storage
    issue_pkg::iq_entry_t entries [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] slot_valid;

    // ready-entry selection
    logic [`IQ_DEPTH-1:0] ready_vec;
    logic [`IQ_DEPTH-1:0] sel_grant;
    logic [`IQ_IDX_W-1:0] sel_idx;
    logic                 any_ready;
    logic                 sel_fire;

    // free-slot selection
    logic [`IQ_DEPTH-1:0] free_vec;
    logic [`IQ_IDX_W-1:0] free_idx;
    logic                 any_free;
    logic                 accept;

    issue_pkg::iq_entry_t new_entry;
    issue_pkg::dispatch_t sel_op;
    issue_pkg::exec_op_t  next_op;

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            ready_vec[i] = slot_valid[i] && entries[i].rdy_a && entries[i].rdy_b;
        end
    end

    assign free_vec = ~slot_valid;

    priority_arbiter #(
        .WIDTH (`IQ_DEPTH)
    ) ready_arb_inst (
        .req       (ready_vec),
        .grant     (sel_grant),
        .grant_idx (sel_idx),
        .any_grant (any_ready)
    );

    priority_arbiter #(
        .WIDTH (`IQ_DEPTH)
    ) free_arb_inst (
        .req       (free_vec),
        .grant     (),
        .grant_idx (free_idx),
        .any_grant (any_free)
    );

    assign iq_full  = !any_free;
    assign accept   = dispatch_valid && !iq_full && !flush;
    // no new pick while execution holds the current op
    assign sel_fire = any_ready && !exec_stall;

    // sources already produced, or produced this very cycle, start ready
    always_comb begin
        new_entry.op    = dispatch;
        new_entry.rdy_a = src_ready_a;
        new_entry.rdy_b = src_ready_b;
    end

    // operand read for the selected slot
    assign sel_op   = entries[sel_idx].op;
    assign rd_tag_a = sel_op.src_a;
    assign rd_tag_b = sel_op.src_b;

    always_comb begin
        next_op.dst            = sel_op.dst;
        next_op.reg_wr         = sel_op.reg_wr;
        next_op.instr          = sel_op.instr;
        next_op.pc             = sel_op.pc;
        next_op.alu_con        = sel_op.alu_con;
        next_op.shamt          = sel_op.shamt;
        next_op.mem_wr         = sel_op.mem_wr;
        next_op.mem_rd         = sel_op.mem_rd;
        next_op.branch         = sel_op.branch;
        next_op.jump           = sel_op.jump;
        next_op.jump_reg       = sel_op.jump_reg;
        next_op.operand_a      = rd_data_a;
        // immediate replaces the second source
        next_op.operand_b      = sel_op.alu_src ? sel_op.imm : rd_data_b;
        next_op.mem_write_data = rd_data_b;
    end

    // control state
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            slot_valid  <= '0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            slot_valid  <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (sel_fire) begin
                slot_valid <= slot_valid & ~sel_grant;
            end
            // free slot never equals the selected one
            if (accept) begin
                slot_valid[free_idx] <= 1'b1;
            end
            if (!exec_stall) begin
                issue_valid <= any_ready;
            end
        end
    end

    // wakeup, slot write and issue register
    always_ff @(posedge CLK) begin
        if (broadcast.valid) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (entries[i].op.src_a == broadcast.tag) begin
                    entries[i].rdy_a <= 1'b1;
                end
                if (entries[i].op.src_b == broadcast.tag) begin
                    entries[i].rdy_b <= 1'b1;
                end
            end
        end
        if (accept) begin
            entries[free_idx] <= new_entry;
        end
        if (sel_fire) begin
            issue_op <= next_op;
        end
    end

    // rename must respect back-pressure
    assert property (@(posedge CLK) disable iff (!RESET)
        !(dispatch_valid && iq_full))
        else $error("issue_queue: dispatch while full");

    // held output while execution is stalled
    assert property (@(posedge CLK) disable iff (!RESET)
        (exec_stall && !flush) |=>
            ($stable(issue_valid) && (!issue_valid || $stable(issue_op))))
        else $error("issue_queue: issue output changed under stall");

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/100ps
`include "issue_consts.svh"

module issue_stage (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   flush,
    input  logic                   dispatch_valid,
    input  issue_pkg::dispatch_t   dispatch,
    output logic                   iq_full,
    input  issue_pkg::broadcast_t  broadcast,
    input  logic                   exec_stall,
    output logic                   issue_valid,
    output issue_pkg::exec_op_t    issue_op
);

    // readiness of the incoming sources
    logic src_ready_a;
    logic src_ready_b;

    // selected entry to register file
    logic [`PREG_W-1:0] rd_tag_a;
    logic [`PREG_W-1:0] rd_tag_b;
    logic [`XLEN-1:0]   rd_data_a;
    logic [`XLEN-1:0]   rd_data_b;

    // only an accepted writer marks its destination busy
    wire alloc_valid = dispatch_valid && !iq_full && dispatch.reg_wr;

    busy_table busy_table_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .flush       (flush),
        .alloc_valid (alloc_valid),
        .alloc_tag   (dispatch.dst),
        .rd_tag_a    (dispatch.src_a),
        .rd_tag_b    (dispatch.src_b),
        .broadcast   (broadcast),
        .ready_a     (src_ready_a),
        .ready_b     (src_ready_b)
    );

    phys_regfile phys_regfile_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .broadcast (broadcast),
        .rd_tag_a  (rd_tag_a),
        .rd_tag_b  (rd_tag_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    issue_queue issue_queue_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .src_ready_a    (src_ready_a),
        .src_ready_b    (src_ready_b),
        .broadcast      (broadcast),
        .exec_stall     (exec_stall),
        .rd_data_a      (rd_data_a),
        .rd_data_b      (rd_data_b),
        .rd_tag_a       (rd_tag_a),
        .rd_tag_b       (rd_tag_b),
        .iq_full        (iq_full),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op)
    );

endmodule

//--- rtl/phys_regfile.sv
`timescale 1ns/100ps
`include "issue_consts.svh"

module phys_regfile (
    input  logic                   CLK,
    input  logic                   RESET,
    input  issue_pkg::broadcast_t  broadcast,
    input  logic [`PREG_W-1:0]     rd_tag_a,
    input  logic [`PREG_W-1:0]     rd_tag_b,
    output logic [`XLEN-1:0]       rd_data_a,
    output logic [`XLEN-1:0]       rd_data_b
);

    logic [`XLEN-1:0] regs [`PREG_COUNT];

    logic wr_en;

    // register 0 holds zero forever
    assign wr_en = broadcast.valid && (broadcast.tag != `PREG_ZERO);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[broadcast.tag] <= broadcast.value;
        end
    end

    // same-cycle result is forwarded ahead of the write
    always_comb begin
        rd_data_a = regs[rd_tag_a];
        rd_data_b = regs[rd_tag_b];
        if (wr_en && (broadcast.tag == rd_tag_a)) begin
            rd_data_a = broadcast.value;
        end
        if (wr_en && (broadcast.tag == rd_tag_b)) begin
            rd_data_b = broadcast.value;
        end
    end

endmodule

//--- rtl/priority_arbiter.sv
`timescale 1ns/100ps

module priority_arbiter #(
    parameter int WIDTH = 16,
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grant,
    output logic [IDX_W-1:0] grant_idx,
    output logic             any_grant
);

    // scan from the top so the lowest requester is written last
    always_comb begin
        grant     = '0;
        grant_idx = '0;
        any_grant = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                grant     = '0;
                grant[i]  = 1'b1;
                grant_idx = IDX_W'(i);
                any_grant = 1'b1;
            end
        end
    end

    // at most one grant, only to a requester, and never idle with requests
    always_comb begin
        assert ($onehot0(grant) && ((grant & ~req) == '0)
                && ((grant == '0) == (req == '0)))
            else $error("priority_arbiter: bad grant %b for req %b", grant, req);
    end

endmodule

//--- sim/tb_issue_stage.sv
`timescale 1ns/100ps
`include "issue_consts.svh"

module tb_issue_stage;

    logic                  CLK;
    logic                  RESET;
    logic                  flush;
    logic                  dispatch_valid;
    issue_pkg::dispatch_t  dispatch;
    logic                  iq_full;
    issue_pkg::broadcast_t broadcast;
    logic                  exec_stall;
    logic                  issue_valid;
    issue_pkg::exec_op_t   issue_op;

    // reference state per physical tag
    logic [`XLEN-1:0] val [`PREG_COUNT];
    bit               pend [`PREG_COUNT];
    bit               alloc [`PREG_COUNT];
    bit               done [`PREG_COUNT];
    int               readers [`PREG_COUNT];
    int               free_q [$];

    // ops waiting in the DUT, and results owed by the execution model
    issue_pkg::dispatch_t exp_q [$];
    int                   bc_tag [$];
    logic [`XLEN-1:0]     bc_val [$];
    int                   bc_due [$];

    int                  seed = 32'hfece;
    int                  cyc;
    int                  stall_pct;
    int                  disp_pct;
    bit                  hold_bcast;
    logic [`XLEN-1:0]    next_pc;
    bit                  prev_valid;
    issue_pkg::exec_op_t prev_op;
    logic [`XLEN-1:0]    last_pc;
    int                  last_cyc;
    string               test_name;
    int                  test_err;
    int                  total_err;
    int                  tests_run;
    int                  tests_failed;

    issue_stage issue_stage_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .iq_full        (iq_full),
        .broadcast      (broadcast),
        .exec_stall     (exec_stall),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic int rnd(int n);
        return int'({$random(seed)} % n);
    endfunction

    task automatic fail_val(string what, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
        $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
        test_err++;
    endtask

    task automatic fail_msg(string what);
        $display("ERROR in %s: %s", test_name, what);
        test_err++;
    endtask

    // completed tags nobody still reads go back to the free list
    task automatic reclaim_tags();
        for (int t = 1; t < `PREG_COUNT; t++) begin
            if (alloc[t] && done[t] && readers[t] == 0) begin
                alloc[t] = 1'b0;
                free_q.push_back(t);
            end
        end
    endtask

    function automatic logic [`PREG_W-1:0] pick_src();
        int pool [$];
        for (int t = 1; t < `PREG_COUNT; t++) begin
            if (alloc[t]) begin
                pool.push_back(t);
            end
        end
        if (pool.size() == 0 || rnd(4) == 0) begin
            return '0;
        end
        return `PREG_W'(pool[rnd(pool.size())]);
    endfunction

    task automatic make_op(output issue_pkg::dispatch_t d);
        d = '0;
        if (free_q.size() < 4) begin
            reclaim_tags();
        end
        d.instr   = $random(seed);
        d.alu_con = 6'(rnd(64));
        d.shamt   = 5'(rnd(32));
        {d.mem_wr, d.mem_rd, d.branch, d.jump, d.jump_reg, d.alu_src} = 6'(rnd(64));
        d.imm     = $random(seed);
        d.src_a   = pick_src();
        d.src_b   = pick_src();
        if (free_q.size() > 0 && rnd(4) != 0) begin
            d.reg_wr = 1'b1;
            d.dst    = `PREG_W'(free_q.pop_front());
        end
        d.pc    = next_pc;
        next_pc = next_pc + 32'd4;
    endtask

    // match a fresh issue against the waiting ops and the value table
    task automatic check_issue();
        issue_pkg::dispatch_t d;
        int                   idx;
        logic [`XLEN-1:0]     exp_a;
        logic [`XLEN-1:0]     exp_b;
        logic [`XLEN-1:0]     exp_w;
        logic [4:0]           exp_f;
        logic [4:0]           act_f;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].pc == issue_op.pc) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            fail_msg($sformatf("pc %h issued but was not waiting in the queue", issue_op.pc));
            return;
        end
        d = exp_q[idx];
        exp_q.delete(idx);
        if (pend[d.src_a] || pend[d.src_b]) begin
            fail_msg($sformatf("pc %h issued while a source was still pending", d.pc));
        end
        exp_a = val[d.src_a];
        exp_w = val[d.src_b];
        exp_b = d.alu_src ? d.imm : exp_w;
        if (issue_op.operand_a !== exp_a) begin
            fail_val("operand_a", exp_a, issue_op.operand_a);
        end
        if (issue_op.operand_b !== exp_b) begin
            fail_val("operand_b", exp_b, issue_op.operand_b);
        end
        if (issue_op.mem_write_data !== exp_w) begin
            fail_val("mem_write_data", exp_w, issue_op.mem_write_data);
        end
        if (issue_op.instr !== d.instr) begin
            fail_val("instr", d.instr, issue_op.instr);
        end
        if (issue_op.dst !== d.dst) begin
            fail_val("dst", 32'(d.dst), 32'(issue_op.dst));
        end
        if (issue_op.reg_wr !== d.reg_wr) begin
            fail_val("reg_wr", 32'(d.reg_wr), 32'(issue_op.reg_wr));
        end
        if (issue_op.alu_con !== d.alu_con) begin
            fail_val("alu_con", 32'(d.alu_con), 32'(issue_op.alu_con));
        end
        if (issue_op.shamt !== d.shamt) begin
            fail_val("shamt", 32'(d.shamt), 32'(issue_op.shamt));
        end
        // mem_wr, mem_rd, branch, jump, jump_reg
        exp_f = {d.mem_wr, d.mem_rd, d.branch, d.jump, d.jump_reg};
        act_f = {issue_op.mem_wr, issue_op.mem_rd, issue_op.branch, issue_op.jump,
                 issue_op.jump_reg};
        if (act_f !== exp_f) begin
            fail_val("control flags", 32'(exp_f), 32'(act_f));
        end
        if (d.src_a != '0) begin
            readers[d.src_a]--;
        end
        if (d.src_b != '0) begin
            readers[d.src_b]--;
        end
        last_pc  = d.pc;
        last_cyc = cyc;
        // result comes back 1 to 4 cycles later
        if (d.reg_wr) begin
            bc_tag.push_back(int'(d.dst));
            bc_val.push_back(exp_a + exp_b);
            bc_due.push_back(cyc + rnd(4));
        end
    endtask

    // effects of the edge just taken
    task automatic observe();
        if (flush) begin
            if (issue_valid !== 1'b0) begin
                fail_val("issue_valid after flush", 32'd0, 32'(issue_valid));
            end
            for (int t = 0; t < `PREG_COUNT; t++) begin
                pend[t]    = 1'b0;
                readers[t] = 0;
                if (alloc[t]) begin
                    done[t] = 1'b1;
                end
            end
            exp_q.delete();
            bc_tag.delete();
            bc_val.delete();
            bc_due.delete();
        end else begin
            if (exec_stall) begin
                if (issue_valid !== prev_valid) begin
                    fail_val("issue_valid under stall", 32'(prev_valid), 32'(issue_valid));
                end else if (prev_valid && issue_op !== prev_op) begin
                    fail_val("issue_op pc under stall", prev_op.pc, issue_op.pc);
                end
            end else if (issue_valid) begin
                check_issue();
            end
            if (broadcast.valid) begin
                val[broadcast.tag]  = broadcast.value;
                pend[broadcast.tag] = 1'b0;
                done[broadcast.tag] = 1'b1;
            end
            if (dispatch_valid) begin
                exp_q.push_back(dispatch);
                if (dispatch.src_a != '0) begin
                    readers[dispatch.src_a]++;
                end
                if (dispatch.src_b != '0) begin
                    readers[dispatch.src_b]++;
                end
                if (dispatch.reg_wr) begin
                    pend[dispatch.dst]  = 1'b1;
                    done[dispatch.dst]  = 1'b0;
                    alloc[dispatch.dst] = 1'b1;
                end
            end
        end
        prev_valid = issue_valid;
        prev_op    = issue_op;
    endtask

    task automatic drive();
        issue_pkg::dispatch_t d;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        broadcast      = '0;
        exec_stall     = (rnd(100) < stall_pct);
        if (!hold_bcast) begin
            for (int i = 0; i < bc_tag.size(); i++) begin
                if (bc_due[i] <= cyc) begin
                    broadcast.valid = 1'b1;
                    broadcast.tag   = `PREG_W'(bc_tag[i]);
                    broadcast.value = bc_val[i];
                    bc_tag.delete(i);
                    bc_val.delete(i);
                    bc_due.delete(i);
                    break;
                end
            end
        end
        if (!iq_full && rnd(100) < disp_pct) begin
            make_op(d);
            dispatch_valid = 1'b1;
            dispatch       = d;
        end
    endtask

    task automatic step();
        @(posedge CLK);
        #1;
        cyc++;
        observe();
        drive();
    endtask

    task automatic run_random(int cycles, int stall, int disp);
        stall_pct = stall;
        disp_pct  = disp;
        repeat (cycles) begin
            step();
        end
    endtask

    task automatic drain();
        int n;
        disp_pct   = 0;
        stall_pct  = 10;
        hold_bcast = 1'b0;
        n = 0;
        do begin
            step();
            n++;
        end while ((exp_q.size() > 0 || bc_tag.size() > 0) && n < 200);
        if (exp_q.size() > 0 || bc_tag.size() > 0) begin
            fail_msg("timeout, instructions or results still outstanding after 200 cycles");
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_err += test_err;
        if (test_err != 0) begin
            tests_failed++;
        end
        $display("test %-8s %s, %0d errors", test_name, (test_err == 0) ? "ok" : "failed",
                 test_err);
    endtask

    initial begin
        issue_pkg::dispatch_t d;
        issue_pkg::dispatch_t p;
        int                   n;
        RESET          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        broadcast      = '0;
        exec_stall     = 1'b0;
        for (int t = 0; t < `PREG_COUNT; t++) begin
            val[t]     = '0;
            pend[t]    = 1'b0;
            alloc[t]   = 1'b0;
            done[t]    = 1'b0;
            readers[t] = 0;
            if (t != 0) begin
                free_q.push_back(t);
            end
        end
        cyc          = 0;
        stall_pct    = 0;
        disp_pct     = 0;
        hold_bcast   = 1'b0;
        next_pc      = 32'h0040_0000;
        prev_valid   = 1'b0;
        prev_op      = '0;
        last_pc      = '0;
        last_cyc     = 0;
        total_err    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge CLK);
        #1 RESET = 1'b1;

        start_test("reset");
        if (issue_valid !== 1'b0) begin
            fail_val("issue_valid", 32'd0, 32'(issue_valid));
        end
        if (iq_full !== 1'b0) begin
            fail_val("iq_full", 32'd0, 32'(iq_full));
        end
        make_op(d);
        d.src_a        = '0;
        d.src_b        = '0;
        d.alu_src      = 1'b0;
        dispatch_valid = 1'b1;
        dispatch       = d;
        n = cyc;
        step();
        step();
        if (last_pc !== d.pc || last_cyc != n + 2) begin
            fail_val("pc issued two edges after dispatch", d.pc, last_pc);
        end else if (prev_op.operand_a !== '0 || prev_op.operand_b !== '0) begin
            fail_val("zero operands", '0, prev_op.operand_a | prev_op.operand_b);
        end
        drain();
        end_test();

        start_test("operands");
        run_random(300, 0, 60);
        drain();
        end_test();

        // one held producer with sixteen consumers waiting on it
        start_test("fill");
        stall_pct = 0;
        disp_pct  = 0;
        make_op(p);
        p.src_a = '0;
        p.src_b = '0;
        if (!p.reg_wr) begin
            reclaim_tags();
            p.reg_wr = 1'b1;
            p.dst    = `PREG_W'(free_q.pop_front());
        end
        hold_bcast     = 1'b1;
        dispatch_valid = 1'b1;
        dispatch       = p;
        n = 0;
        do begin
            step();
            n++;
        end while (exp_q.size() > 0 && n < 200);
        if (exp_q.size() > 0) begin
            fail_msg("timeout, producer never issued");
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (iq_full) begin
                fail_msg("queue reported full before 16 entries");
            end else begin
                make_op(d);
                d.src_a        = p.dst;
                d.src_b        = p.dst;
                dispatch_valid = 1'b1;
                dispatch       = d;
            end
            step();
        end
        if (iq_full !== 1'b1) begin
            fail_val("iq_full", 32'd1, 32'(iq_full));
        end
        hold_bcast = 1'b0;
        n = 0;
        while (iq_full && n < 200) begin
            step();
            n++;
        end
        if (iq_full) begin
            fail_msg("timeout, iq_full never fell after wakeup");
        end
        drain();
        end_test();

        start_test("stall");
        run_random(400, 50, 70);
        drain();
        end_test();

        start_test("flush");
        run_random(40, 70, 80);
        // a dispatch cancelled by the flush gives its tag back
        if (dispatch_valid && dispatch.reg_wr) begin
            free_q.push_back(int'(dispatch.dst));
        end
        dispatch_valid = 1'b0;
        broadcast      = '0;
        flush          = 1'b1;
        step();
        run_random(150, 20, 60);
        drain();
        end_test();

        start_test("random");
        run_random(2000, 25, 70);
        drain();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_err);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
